// File: common/icache_macros.svh
////////////////////////////////////////////////////////////////////////////
// Instruction cache geometry shared by packages and RTL
// ICACHE_DW is both the fetch window and the AXI data width
// A line must hold at least two windows (ICACHE_P_LINE > 3)
////////////////////////////////////////////////////////////////////////////

`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Physical address width in bits
`define ICACHE_AW 32

// Set index bits, 16 sets
`define ICACHE_P_SETS 4

// Line offset bits, 16-byte lines
`define ICACHE_P_LINE 4

// Associativity
`define ICACHE_WAYS 2

// Fetch window and bus width
`define ICACHE_DW 64

// Whatever is left above index and offset
`define ICACHE_TAG_W (`ICACHE_AW - `ICACHE_P_SETS - `ICACHE_P_LINE)

`endif

// File: common/icache_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Cache-side types for the instruction cache
// Widths come from icache_macros.svh
////////////////////////////////////////////////////////////////////////////

`include "icache_macros.svh"

package icache_pkg;

   // Windows per line, as an index width
   localparam int BEAT_W = `ICACHE_P_LINE - $clog2(`ICACHE_DW / 8);

   typedef struct packed {
      logic                   valid;
      logic [`ICACHE_AW-1:0]  paddr;   // Aligned to the fetch window
   } fetch_req_t;

   typedef struct packed {
      logic [`ICACHE_TAG_W-1:0] tag;
      logic                     v;
   } tag_entry_t;

   typedef logic [`ICACHE_DW-1:0] payload_t;

   typedef enum logic [2:0] {BOOT, IDLE, REPLACE, REFILL, INVALIDATE} ctrl_state_t;

   // Write command toward the tag and payload arrays
   typedef struct packed {
      logic                       we;
      logic [`ICACHE_P_SETS-1:0]  set;
      logic [`ICACHE_WAYS-1:0]    way;    // One bit per way
      logic [BEAT_W-1:0]          beat;
   } ram_wr_t;

endpackage

// File: common/axi_rd_pkg.sv
////////////////////////////////////////////////////////////////////////////
// AXI read channel types, INCR bursts only
// Side-band fields are not carried
////////////////////////////////////////////////////////////////////////////

`include "icache_macros.svh"

package axi_rd_pkg;

   // AR channel request
   typedef struct packed {
      logic [`ICACHE_AW-1:0]  addr;
      logic [7:0]             len;    // Beats minus one
      logic [2:0]             size;   // Log2 of bytes per beat
   } axi_ar_t;

   // R channel beat, response code not carried
   typedef struct packed {
      logic [`ICACHE_DW-1:0]  data;
      logic                   last;
   } axi_r_t;

endpackage

// File: icache/icache_ram.sv
////////////////////////////////////////////////////////////////////////////
// Single-port RAM with registered read
// Read output only updates while en_i is high and holds otherwise
// Writes do not depend on en_i. Contents are undefined after power-up
////////////////////////////////////////////////////////////////////////////

module icache_ram
#(
   parameter type entry_t = logic [31:0],
   parameter int  DEPTH   = 16
)
(
   input  logic                      clk,
   input  logic                      en_i,
   input  logic                      we_i,
   input  logic [$clog2(DEPTH)-1:0]  addr_i,
   input  entry_t                    wdata_i,
   output entry_t                    rdata_o
);

   entry_t mem [DEPTH];

   always_ff @(posedge clk)
   begin
      if (we_i)
         mem[addr_i] <= wdata_i;
      // Old contents on a same-cycle write
      if (en_i)
         rdata_o <= mem[addr_i];
   end

endmodule

// File: icache/icache_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Instruction cache controller FSM
// Boot sweep clears one set per cycle; invalidate takes a single cycle
// Round-robin victim pointer steps once per completed refill
////////////////////////////////////////////////////////////////////////////

`include "icache_macros.svh"

module icache_ctrl
(
   input  logic                        clk,
   input  logic                        arst_n_i,
   input  icache_pkg::fetch_req_t      fetch_req_i,   // Stage-1 request
   input  logic                        inv_i,
   input  logic [`ICACHE_AW-1:0]       inv_paddr_i,
   input  logic                        s2_miss_i,
   input  logic [`ICACHE_AW-1:0]       s2_paddr_i,
   input  logic                        refill_done_i,
   output icache_pkg::ctrl_state_t     state_o,
   output icache_pkg::ram_wr_t         tag_wr_o,
   output icache_pkg::tag_entry_t      tag_din_o,
   output logic [`ICACHE_P_SETS-1:0]   tag_addr_o,
   output logic                        stall_o,
   output logic                        ar_load_o
);

   localparam int VW = $clog2(`ICACHE_WAYS);

   icache_pkg::ctrl_state_t   state_q;
   icache_pkg::ctrl_state_t   state_nxt;
   logic [`ICACHE_P_SETS-1:0] sweep_q;
   logic [`ICACHE_P_SETS-1:0] inv_set_q;
   logic [VW-1:0]             victim_q;

   always_comb
   begin
      state_nxt = state_q;
      case (state_q)
         icache_pkg::BOOT:
            if (&sweep_q)
               state_nxt = icache_pkg::IDLE;   // Last set cleared
         icache_pkg::IDLE:
            if (inv_i)
               state_nxt = icache_pkg::INVALIDATE;
            else if (s2_miss_i)
               state_nxt = icache_pkg::REPLACE;
         icache_pkg::REPLACE:
            state_nxt = icache_pkg::REFILL;
         icache_pkg::REFILL:
            if (refill_done_i)
               state_nxt = icache_pkg::IDLE;
         icache_pkg::INVALIDATE:
            state_nxt = icache_pkg::IDLE;
         default:
            state_nxt = icache_pkg::BOOT;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q  <= icache_pkg::BOOT;
         sweep_q  <= '0;
         victim_q <= '0;
      end
      else
      begin
         state_q <= state_nxt;
         if (state_q == icache_pkg::BOOT)
            sweep_q <= sweep_q + 1'b1;
         if (state_q == icache_pkg::REFILL && refill_done_i)
            victim_q <= victim_q + 1'b1;   // Next victim once the line is in
      end
   end

   // Set to clear, latched with the request
   always_ff @(posedge clk)
   begin
      if (state_q == icache_pkg::IDLE && inv_i)
         inv_set_q <= inv_paddr_i[`ICACHE_P_LINE +: `ICACHE_P_SETS];
   end

   always_comb
   begin
      case (state_q)
         icache_pkg::BOOT:       tag_addr_o = sweep_q;
         icache_pkg::REPLACE:    tag_addr_o = s2_paddr_i[`ICACHE_P_LINE +: `ICACHE_P_SETS];
         icache_pkg::INVALIDATE: tag_addr_o = inv_set_q;
         default:                tag_addr_o = fetch_req_i.paddr[`ICACHE_P_LINE +: `ICACHE_P_SETS];
      endcase
   end

   always_comb
   begin
      tag_wr_o.we   = (state_q == icache_pkg::BOOT) || (state_q == icache_pkg::REPLACE) ||
                      (state_q == icache_pkg::INVALIDATE);
      tag_wr_o.set  = tag_addr_o;
      tag_wr_o.beat = '0;
      if (state_q == icache_pkg::REPLACE || state_q == icache_pkg::REFILL)
      begin
         tag_wr_o.way           = '0;
         tag_wr_o.way[victim_q] = 1'b1;   // Victim only
      end
      else
         tag_wr_o.way = '1;               // Clear every way
   end

   always_comb
   begin
      tag_din_o = '0;
      if (state_q == icache_pkg::REPLACE)
      begin
         tag_din_o.tag = s2_paddr_i[`ICACHE_AW-1 -: `ICACHE_TAG_W];
         tag_din_o.v   = 1'b1;
      end
   end

   assign stall_o   = (state_q != icache_pkg::IDLE) || s2_miss_i;
   assign ar_load_o = (state_q == icache_pkg::REPLACE);
   assign state_o   = state_q;

endmodule

// File: icache/icache_lookup.sv
////////////////////////////////////////////////////////////////////////////
// Stage-2 tag compare and output window register
// After a refill the held request retires from the bus copy
////////////////////////////////////////////////////////////////////////////

`include "icache_macros.svh"

module icache_lookup
(
   input  logic                                         clk,
   input  logic                                         arst_n_i,
   input  icache_pkg::fetch_req_t                       s2_req_i,
   input  icache_pkg::tag_entry_t [`ICACHE_WAYS-1:0]    tag_i,
   input  icache_pkg::payload_t   [`ICACHE_WAYS-1:0]    data_i,
   input  icache_pkg::ctrl_state_t                      state_i,
   input  logic                                         bypass_we_i,
   input  icache_pkg::payload_t                         bypass_data_i,
   input  logic                                         stall_i,
   output logic                                         s2_miss_o,
   output icache_pkg::payload_t                         ins_o,
   output logic                                         valid_o
);

   localparam int HW = $clog2(`ICACHE_WAYS);

   logic [`ICACHE_WAYS-1:0] hit_vec;
   logic [HW-1:0]           hit_way;
   logic                    refilled_q;   // Stage 2 already served by refill

   always_comb
   begin
      hit_way = '0;
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
         hit_vec[w] = tag_i[w].v && (tag_i[w].tag == s2_req_i.paddr[`ICACHE_AW-1 -: `ICACHE_TAG_W]);
         if (hit_vec[w])
            hit_way = HW'(w);
      end
   end

   assign s2_miss_o = s2_req_i.valid && !(|hit_vec) && !refilled_q &&
                      (state_i == icache_pkg::IDLE);

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         refilled_q <= 1'b0;
         valid_o    <= 1'b0;
      end
      else
      begin
         if (state_i == icache_pkg::REFILL)
            refilled_q <= 1'b1;
         else if (!stall_i)
            refilled_q <= 1'b0;
         valid_o <= !stall_i && s2_req_i.valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (bypass_we_i)
         ins_o <= bypass_data_i;     // Requested beat off the bus
      else if (!stall_i && !refilled_q)
         ins_o <= data_i[hit_way];
   end

endmodule

// File: icache/icache_refill.sv
////////////////////////////////////////////////////////////////////////////
// Line refill over AXI, one INCR burst per miss
// Beats are assumed to arrive in address order starting at the line base
////////////////////////////////////////////////////////////////////////////

`include "icache_macros.svh"

module icache_refill
(
   input  logic                                              clk,
   input  logic                                              arst_n_i,
   input  icache_pkg::ctrl_state_t                           state_i,
   input  logic                                              ar_load_i,
   input  logic [`ICACHE_AW-1:0]                             miss_paddr_i,
   input  logic                                              ar_ready_i,
   input  logic                                              r_valid_i,
   input  axi_rd_pkg::axi_r_t                                r_i,
   output logic                                              ar_valid_o,
   output axi_rd_pkg::axi_ar_t                               ar_o,
   output logic                                              r_ready_o,
   output logic                                              pay_we_o,
   output logic [`ICACHE_P_SETS+icache_pkg::BEAT_W-1:0]      pay_addr_o,
   output icache_pkg::payload_t                              pay_din_o,
   output logic                                              bypass_we_o,
   output logic                                              refill_done_o
);

   localparam int BW  = icache_pkg::BEAT_W;
   localparam int OFS = `ICACHE_P_LINE - BW;   // Byte offset bits in a beat

   logic          r_hs;
   logic [BW-1:0] beat_q;

   assign r_ready_o = (state_i == icache_pkg::REFILL);
   assign r_hs      = r_valid_i && r_ready_o;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         ar_valid_o <= 1'b0;
      else if (ar_load_i)
         ar_valid_o <= 1'b1;
      else if (ar_valid_o && ar_ready_i)
         ar_valid_o <= 1'b0;
   end

   // Held stable until the handshake
   always_ff @(posedge clk)
   begin
      if (ar_load_i)
      begin
         ar_o.addr <= {miss_paddr_i[`ICACHE_AW-1:`ICACHE_P_LINE], {`ICACHE_P_LINE{1'b0}}};
         ar_o.len  <= 8'((1 << BW) - 1);
         ar_o.size <= 3'(OFS);
      end
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         beat_q <= '0;
      else if (!r_ready_o)
         beat_q <= '0;
      else if (r_hs)
         beat_q <= beat_q + 1'b1;
   end

   assign pay_we_o      = r_hs;
   assign pay_addr_o    = {miss_paddr_i[`ICACHE_P_LINE +: `ICACHE_P_SETS], beat_q};
   assign pay_din_o     = r_i.data;
   assign bypass_we_o   = r_hs && (beat_q == miss_paddr_i[OFS +: BW]);  // Window asked for
   assign refill_done_o = r_hs && r_i.last;

endmodule

// File: icache/icache_top.sv
////////////////////////////////////////////////////////////////////////////
// Two-way instruction cache, physical addresses, two-cycle hit latency
// Consumer must take every valid_o; AXI responses are not checked
////////////////////////////////////////////////////////////////////////////

`include "icache_macros.svh"

module icache_top
(
   input  logic                     clk,
   input  logic                     arst_n_i,
   input  icache_pkg::fetch_req_t   fetch_req_i,
   input  logic                     inv_i,
   input  logic [`ICACHE_AW-1:0]    inv_paddr_i,
   output logic                     stall_o,
   output icache_pkg::payload_t     ins_o,
   output logic                     valid_o,
   output logic                     ar_valid_o,
   output axi_rd_pkg::axi_ar_t      ar_o,
   input  logic                     ar_ready_i,
   input  logic                     r_valid_i,
   input  axi_rd_pkg::axi_r_t       r_i,
   output logic                     r_ready_o
);

   localparam int BW     = icache_pkg::BEAT_W;
   localparam int PAY_AW = `ICACHE_P_SETS + BW;

   icache_pkg::fetch_req_t                      s1_req;
   icache_pkg::fetch_req_t                      s2_req;
   icache_pkg::ctrl_state_t                     state;
   icache_pkg::ram_wr_t                         tag_wr;
   icache_pkg::ram_wr_t                         pay_wr;
   icache_pkg::tag_entry_t                      tag_din;
   logic [`ICACHE_P_SETS-1:0]                   tag_addr;
   icache_pkg::tag_entry_t [`ICACHE_WAYS-1:0]   tag_rd;
   icache_pkg::payload_t   [`ICACHE_WAYS-1:0]   data_rd;
   logic                                        s2_miss;
   logic                                        ar_load;
   logic                                        pay_we;
   logic [PAY_AW-1:0]                           pay_addr;
   logic [PAY_AW-1:0]                           pay_ram_addr;
   icache_pkg::payload_t                        pay_din;
   logic                                        bypass_we;
   logic                                        refill_done;

   // Both stages hold while stalled
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         s1_req <= '0;
         s2_req <= '0;
      end
      else if (!stall_o)
      begin
         s1_req <= fetch_req_i;
         s2_req <= s1_req;
      end
   end

   // Refill writes go to the victim way
   assign pay_wr.we   = pay_we;
   assign pay_wr.set  = pay_addr[PAY_AW-1 -: `ICACHE_P_SETS];
   assign pay_wr.way  = tag_wr.way;
   assign pay_wr.beat = pay_addr[BW-1:0];

   assign pay_ram_addr = pay_wr.we ? {pay_wr.set, pay_wr.beat}
                                   : s1_req.paddr[`ICACHE_P_LINE-BW +: PAY_AW];

   for (genvar w = 0; w < `ICACHE_WAYS; w++)
   begin : g_way
      icache_ram #(
         .entry_t (icache_pkg::tag_entry_t),
         .DEPTH   (1 << `ICACHE_P_SETS)
      ) u_tag_ram (
         .clk     (clk),
         .en_i    (!stall_o),
         .we_i    (tag_wr.we && tag_wr.way[w]),
         .addr_i  (tag_addr),
         .wdata_i (tag_din),
         .rdata_o (tag_rd[w])
      );

      icache_ram #(
         .entry_t (icache_pkg::payload_t),
         .DEPTH   (1 << PAY_AW)
      ) u_pay_ram (
         .clk     (clk),
         .en_i    (!stall_o),
         .we_i    (pay_wr.we && pay_wr.way[w]),
         .addr_i  (pay_ram_addr),
         .wdata_i (pay_din),
         .rdata_o (data_rd[w])
      );
   end

   icache_ctrl u_ctrl (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .fetch_req_i   (s1_req),
      .inv_i         (inv_i),
      .inv_paddr_i   (inv_paddr_i),
      .s2_miss_i     (s2_miss),
      .s2_paddr_i    (s2_req.paddr),
      .refill_done_i (refill_done),
      .state_o       (state),
      .tag_wr_o      (tag_wr),
      .tag_din_o     (tag_din),
      .tag_addr_o    (tag_addr),
      .stall_o       (stall_o),
      .ar_load_o     (ar_load)
   );

   icache_lookup u_lookup (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .s2_req_i      (s2_req),
      .tag_i         (tag_rd),
      .data_i        (data_rd),
      .state_i       (state),
      .bypass_we_i   (bypass_we),
      .bypass_data_i (pay_din),
      .stall_i       (stall_o),
      .s2_miss_o     (s2_miss),
      .ins_o         (ins_o),
      .valid_o       (valid_o)
   );

   icache_refill u_refill (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .state_i       (state),
      .ar_load_i     (ar_load),
      .miss_paddr_i  (s2_req.paddr),
      .ar_ready_i    (ar_ready_i),
      .r_valid_i     (r_valid_i),
      .r_i           (r_i),
      .ar_valid_o    (ar_valid_o),
      .ar_o          (ar_o),
      .r_ready_o     (r_ready_o),
      .pay_we_o      (pay_we),
      .pay_addr_o    (pay_addr),
      .pay_din_o     (pay_din),
      .bypass_we_o   (bypass_we),
      .refill_done_o (refill_done)
   );

endmodule

// File: bench/axi_mem_model.sv
////////////////////////////////////////////////////////////////////////////
// AXI read slave for the cache testbench, one burst at a time
// Beats are 8 bytes wide; each 32-bit word reads as its address ^ 32'h4e660000
// AR acceptance is delayed at random, R beats follow back to back
////////////////////////////////////////////////////////////////////////////

`include "icache_macros.svh"

module axi_mem_model
(
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  logic                  ar_valid_i,
   input  axi_rd_pkg::axi_ar_t   ar_i,
   output logic                  ar_ready_o,
   output logic                  r_valid_o,
   output axi_rd_pkg::axi_r_t    r_o,
   input  logic                  r_ready_i
);

   integer                seed;
   logic [31:0]           rnd;
   logic [`ICACHE_AW-1:0] base_q;
   logic [`ICACHE_AW-1:0] beat_addr;
   logic [7:0]            beat_q;
   logic [7:0]            len_q;
   logic                  busy_q;      // Burst in progress

   function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
      return byte_addr ^ 32'h4e66_0000;
   endfunction

   initial
   begin
      seed       = 32'h4e66;
      ar_ready_o = 1'b0;
      r_valid_o  = 1'b0;
      r_o        = '0;
      base_q     = '0;
      beat_q     = 8'd0;
      len_q      = 8'd0;
      busy_q     = 1'b0;
      forever
      begin
         // Handshakes as seen at the rising edge
         @(posedge clk);
         if (!arst_n_i)
            busy_q = 1'b0;
         else if (r_valid_o && r_ready_i)
         begin
            if (beat_q == len_q)
               busy_q = 1'b0;
            else
               beat_q = beat_q + 8'd1;
         end
         else if (ar_valid_i && ar_ready_o)
         begin
            base_q = ar_i.addr;
            len_q  = ar_i.len;
            beat_q = 8'd0;
            busy_q = 1'b1;
         end
         @(negedge clk);
         rnd        = $random(seed);
         ar_ready_o = !busy_q && (rnd[1:0] == 2'b00);   // Ready one cycle in four
         beat_addr  = base_q + {21'd0, beat_q, 3'd0};
         r_valid_o  = busy_q;
         r_o.data   = {mem_word(beat_addr + 32'd4), mem_word(beat_addr)};
         r_o.last   = (beat_q == len_q);
      end
   end

endmodule

// File: bench/icache_tb.sv
////////////////////////////////////////////////////////////////////////////
// Instruction cache testbench with a reference tag model
// Invalidate is only issued with no fetch in flight
////////////////////////////////////////////////////////////////////////////

`include "icache_macros.svh"

module icache_tb;

   localparam int          N_REQ = 55;
   localparam logic [31:0] LIMIT = 32'(40 * N_REQ + 100);
   localparam int          SETS  = 1 << `ICACHE_P_SETS;

   typedef struct packed {
      logic [`ICACHE_AW-1:0] addr;
      logic [31:0]           acc;     // Cycle of acceptance
      logic                  miss;
      logic                  timed;   // Hit with nothing stalled ahead
   } pend_t;

   logic                      clk = 1'b0;
   logic                      arst_n_i;
   icache_pkg::fetch_req_t    fetch_req_i;
   logic                      inv_i;
   logic [`ICACHE_AW-1:0]     inv_paddr_i;
   logic                      stall_o;
   icache_pkg::payload_t      ins_o;
   logic                      valid_o;
   logic                      ar_valid_o;
   axi_rd_pkg::axi_ar_t       ar_o;
   logic                      ar_ready_i;
   logic                      r_valid_i;
   axi_rd_pkg::axi_r_t        r_i;
   logic                      r_ready_o;

   // Reference tag store with one global round-robin victim
   logic [`ICACHE_TAG_W-1:0]  tag_m [SETS][2];
   logic                      val_m [SETS][2];
   logic                      victim_m = 1'b0;

   pend_t                     pend_q[$];
   logic                      ar_wait = 1'b0;
   axi_rd_pkg::axi_ar_t       ar_held;
   logic                      boot_done = 1'b0;
   logic [31:0]               boot_cnt = 32'd0;
   logic [31:0]               cyc = 32'd0;
   int                        errors = 0;
   int                        requests = 0;
   int                        responses = 0;
   int                        bursts = 0;
   int                        misses = 0;
   int                        misses_done = 0;
   int                        miss_open = 0;
   integer                    seed;
   logic [31:0]               rnd;

   always #50 clk = ~clk;

   icache_top UUT (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .fetch_req_i (fetch_req_i),
      .inv_i       (inv_i),
      .inv_paddr_i (inv_paddr_i),
      .stall_o     (stall_o),
      .ins_o       (ins_o),
      .valid_o     (valid_o),
      .ar_valid_o  (ar_valid_o),
      .ar_o        (ar_o),
      .ar_ready_i  (ar_ready_i),
      .r_valid_i   (r_valid_i),
      .r_i         (r_i),
      .r_ready_o   (r_ready_o)
   );

   axi_mem_model u_mem (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .ar_valid_i (ar_valid_o),
      .ar_i       (ar_o),
      .ar_ready_o (ar_ready_i),
      .r_valid_o  (r_valid_i),
      .r_o        (r_i),
      .r_ready_i  (r_ready_o)
   );

   function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
      return byte_addr ^ 32'h4e66_0000;
   endfunction

   // Lower address in the lower half
   function automatic icache_pkg::payload_t expected_window(input logic [31:0] addr);
      return {mem_word(addr + 32'd4), mem_word(addr)};
   endfunction

   task automatic record_failure(input string msg);
      errors++;
      $display("FAILED at time %0t: %s", $time, msg);
   endtask

   task automatic predict_lookup(input logic [31:0] addr, output logic hit);
      logic [`ICACHE_P_SETS-1:0] set;
      logic [`ICACHE_TAG_W-1:0]  tag;
      set = addr[`ICACHE_P_LINE +: `ICACHE_P_SETS];
      tag = addr[`ICACHE_AW-1 -: `ICACHE_TAG_W];
      hit = (val_m[set][0] && tag_m[set][0] == tag) || (val_m[set][1] && tag_m[set][1] == tag);
      if (!hit)
      begin
         tag_m[set][victim_m] = tag;
         val_m[set][victim_m] = 1'b1;
         victim_m = ~victim_m;
      end
   endtask

   // Invalidate clears both ways of the set
   task automatic clear_set(input logic [31:0] addr);
      logic [`ICACHE_P_SETS-1:0] set;
      set = addr[`ICACHE_P_LINE +: `ICACHE_P_SETS];
      val_m[set][0] = 1'b0;
      val_m[set][1] = 1'b0;
   endtask

   task automatic accept_request;
      pend_t e;
      logic  hit;
      predict_lookup(fetch_req_i.paddr, hit);
      e.addr  = fetch_req_i.paddr;
      e.acc   = cyc;
      e.miss  = !hit;
      e.timed = hit && (miss_open == 0);
      if (!hit)
      begin
         misses++;
         miss_open++;
      end
      pend_q.push_back(e);
      requests++;
   endtask

   task automatic retire_response;
      pend_t e;
      if (pend_q.size() == 0)
         record_failure("valid_o with no request outstanding");
      else
      begin
         e = pend_q.pop_front();
         responses++;
         assert (ins_o == expected_window(e.addr))
         else record_failure($sformatf("window for %h is %h, expected %h",
                                       e.addr, ins_o, expected_window(e.addr)));
         if (e.miss)
         begin
            misses_done++;
            miss_open--;
         end
         assert (bursts == misses_done)
         else record_failure($sformatf("%0d AR bursts after %0d misses", bursts, misses_done));
         // valid_o rose on the edge before this one
         assert (!e.timed || cyc == e.acc + 32'd3)
         else record_failure($sformatf("hit on %h took %0d cycles, expected 2",
                                       e.addr, cyc - e.acc - 32'd1));
      end
   endtask

   task automatic report;
      $display("Requests %0d, responses %0d, AR bursts %0d, errors %0d",
               requests, responses, bursts, errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   endtask

   always @(posedge clk)
   begin
      if (arst_n_i)
      begin
         cyc = cyc + 32'd1;
         if (!boot_done)
         begin
            assert (!valid_o && !ar_valid_o && !r_ready_o)
            else record_failure("valid_o, ar_valid_o or r_ready_o high during boot");
            if (stall_o)
               boot_cnt = boot_cnt + 32'd1;
            else
            begin
               boot_done = 1'b1;
               assert (boot_cnt == 32'd16)
               else record_failure($sformatf("boot stall lasted %0d cycles", boot_cnt));
            end
         end
         if (valid_o)
            retire_response();
         if (ar_wait)
            assert (ar_valid_o && ar_o == ar_held)
            else record_failure("AR request changed before its handshake");
         if (ar_valid_o && ar_ready_i)
         begin
            bursts++;
            assert (pend_q.size() != 0 && pend_q[0].miss && ar_o.len == 8'd1 &&
                    ar_o.size == 3'd3 && ar_o.addr ==
                    {pend_q[0].addr[`ICACHE_AW-1:`ICACHE_P_LINE], {`ICACHE_P_LINE{1'b0}}})
            else record_failure($sformatf("unexpected AR addr %h len %0d size %0d",
                                          ar_o.addr, ar_o.len, ar_o.size));
         end
         assert (!r_ready_o || miss_open != 0)
         else record_failure("r_ready_o high with no miss outstanding");
         ar_wait = ar_valid_o && !ar_ready_i;
         ar_held = ar_o;
         if (inv_i && !stall_o)
            clear_set(inv_paddr_i);
         if (fetch_req_i.valid && !stall_o)
            accept_request();
         if (cyc >= LIMIT)
         begin
            errors++;
            $display("Timeout: run stopped after %0d cycles with %0d requests still waiting",
                     cyc, pend_q.size());
            report();
         end
      end
   end

   // Called on a falling edge and returns on the falling edge after acceptance
   task automatic fetch(input logic [31:0] addr);
      logic taken;
      fetch_req_i.valid = 1'b1;
      fetch_req_i.paddr = addr;
      taken = 1'b0;
      while (!taken)
      begin
         @(posedge clk);
         taken = !stall_o;
         @(negedge clk);
      end
      fetch_req_i.valid = 1'b0;
   endtask

   task automatic drain;
      while (pend_q.size() != 0)
         @(negedge clk);
   endtask

   task automatic invalidate(input logic [31:0] addr);
      inv_i       = 1'b1;
      inv_paddr_i = addr;
      @(negedge clk);
      inv_i = 1'b0;
      assert (stall_o) else record_failure("stall_o low in the invalidate cycle");
      @(negedge clk);
      assert (!stall_o) else record_failure("stall_o still high one cycle after invalidate");
   endtask

   initial
   begin
      arst_n_i    = 1'b0;
      fetch_req_i = '0;
      inv_i       = 1'b0;
      inv_paddr_i = '0;
      seed        = 32'h4e66;
      for (int s = 0; s < SETS; s++)
      begin
         val_m[s][0] = 1'b0;
         val_m[s][1] = 1'b0;
      end
      repeat (3) @(negedge clk);
      arst_n_i = 1'b1;
      while (!boot_done)
         @(negedge clk);
      fetch(32'h0000_1000);     // Miss with a hit queued behind it
      fetch(32'h0000_1008);
      drain();
      fetch(32'h0000_1008);
      fetch(32'h0000_1000);
      drain();
      // Three lines competing for set 2
      fetch(32'h0000_2020);
      fetch(32'h0000_3020);
      fetch(32'h0000_2028);
      fetch(32'h0000_4020);
      fetch(32'h0000_2020);
      fetch(32'h0000_3028);
      fetch(32'h0000_4020);
      fetch(32'h0000_4028);
      drain();
      repeat (40)
      begin
         rnd = $random(seed);
         fetch(32'h0001_0000 | (rnd & 32'h0000_3078));   // Spread over 8 sets and 4 tags
      end
      drain();
      fetch(32'h0000_5040);
      drain();
      fetch(32'h0000_5040);
      drain();
      invalidate(32'h0000_5040);
      fetch(32'h0000_5048);
      drain();
      assert (bursts == misses)
      else record_failure($sformatf("%0d AR bursts for %0d predicted misses", bursts, misses));
      report();
   end

endmodule

// File: icache_top.f
+incdir+common
common/icache_pkg.sv
common/axi_rd_pkg.sv
icache/icache_ram.sv
icache/icache_ctrl.sv
icache/icache_lookup.sv
icache/icache_refill.sv
icache/icache_top.sv
bench/axi_mem_model.sv
bench/icache_tb.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing --assert -Wall
TOP        = icache_tb
FILELIST   = icache_top.f
OBJ_DIR    = obj_dir
PASS_MSG   = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
